// File: hw/cmo_pkg.sv
// Shared cache geometry, address field types, operation enum and request structs
// Address field helpers for set and tag extraction
package cmo_pkg;

    // Cache geometry
    localparam int CMO_OFFSET_WIDTH = 4;
    localparam int CMO_SETS         = 16;
    localparam int CMO_SET_WIDTH    = 4;
    localparam int CMO_WAYS         = 4;
    localparam int CMO_TAG_WIDTH    = 8;
    localparam int CMO_ADDR_WIDTH   = CMO_OFFSET_WIDTH + CMO_SET_WIDTH + CMO_TAG_WIDTH;
    localparam int CMO_DATA_WIDTH   = 32;

    typedef logic [CMO_ADDR_WIDTH-1:0] cmo_addr_t;
    typedef logic [CMO_SET_WIDTH-1:0]  cmo_set_t;
    typedef logic [CMO_TAG_WIDTH-1:0]  cmo_tag_t;
    typedef logic [CMO_WAYS-1:0]       cmo_way_vec_t;
    typedef logic [CMO_DATA_WIDTH-1:0] cmo_data_t;

    typedef enum logic [1:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_SET,
        CMO_INVAL_ALL
    } cmo_op_e;

    // Way mask for invalidate-by-set sits in the low bits of wdata
    typedef struct packed {
        cmo_op_e   op;
        cmo_addr_t addr;
        cmo_data_t wdata;
    } cmo_req_t;

    typedef struct packed {
        cmo_set_t     set;
        cmo_way_vec_t way;
        cmo_tag_t     tag;
    } dir_fill_t;

    typedef struct packed {
        cmo_addr_t addr;
        cmo_data_t data;
    } wbuf_wr_t;

    // Set index is the low part of the line number
    function automatic cmo_set_t cmo_addr_set(cmo_addr_t addr);
        return addr[CMO_OFFSET_WIDTH +: CMO_SET_WIDTH];
    endfunction

    function automatic cmo_tag_t cmo_addr_tag(cmo_addr_t addr);
        return addr[CMO_OFFSET_WIDTH + CMO_SET_WIDTH +: CMO_TAG_WIDTH];
    endfunction

endpackage

// File: hw/cmo_handler.sv
// Cache-management operation handler FSM
// Fence drain, line, set and full-cache invalidation sequencing
module cmo_handler (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Request port
    input  logic                  req_valid_i,
    input  cmo_pkg::cmo_req_t     req_i,
    input  logic                  mem_inval_i,
    output logic                  req_ready_o,
    output logic                  req_wait_o,

    // Quiet levels
    input  logic                  wbuf_empty_i,
    input  logic                  mshr_empty_i,
    input  logic                  rtab_empty_i,
    input  logic                  ctrl_empty_i,

    output logic                  wbuf_flush_all_o,

    // Directory check and invalidate
    output logic                  dir_check_o,
    output cmo_pkg::cmo_set_t     dir_check_set_o,
    output cmo_pkg::cmo_tag_t     dir_check_tag_o,
    input  cmo_pkg::cmo_way_vec_t dir_check_hit_i,
    output logic                  dir_inval_o,
    output cmo_pkg::cmo_set_t     dir_inval_set_o,
    output cmo_pkg::cmo_way_vec_t dir_inval_way_o,
    input  logic                  dir_busy_i
);

    typedef enum logic [2:0] {
        IDLE,
        FENCE_WAIT,
        INVAL_WAIT,
        CHECK_NLINE,
        INVAL_SET
    } state_e;

    state_e                state_q, state_d;
    cmo_pkg::cmo_op_e      op_q, op_d;
    cmo_pkg::cmo_addr_t    addr_q, addr_d;
    cmo_pkg::cmo_way_vec_t way_q, way_d;
    cmo_pkg::cmo_set_t     set_cnt_q, set_cnt_d;
    logic                  mem_inval_q, mem_inval_d;
    logic                  quiet;
    state_e                inval_start;

    // Invalidations other than memory ones need the whole cache quiet
    assign quiet = mshr_empty_i && rtab_empty_i && ctrl_empty_i;

    // First working state of a non-memory invalidation
    assign inval_start = (op_d == cmo_pkg::CMO_INVAL_NLINE) ? CHECK_NLINE : INVAL_SET;

    assign req_ready_o     = (state_q == IDLE);
    assign dir_check_set_o = cmo_pkg::cmo_addr_set(addr_q);
    assign dir_check_tag_o = cmo_pkg::cmo_addr_tag(addr_q);

    always_comb begin
        state_d          = state_q;
        op_d             = op_q;
        addr_d           = addr_q;
        way_d            = way_q;
        set_cnt_d        = set_cnt_q;
        mem_inval_d      = mem_inval_q;

        req_wait_o       = 1'b0;
        wbuf_flush_all_o = 1'b0;
        dir_check_o      = 1'b0;
        dir_inval_o      = 1'b0;
        dir_inval_set_o  = cmo_pkg::cmo_addr_set(addr_q);
        dir_inval_way_o  = '0;

        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    op_d        = req_i.op;
                    addr_d      = req_i.addr;
                    way_d       = req_i.wdata[cmo_pkg::CMO_WAYS-1:0];
                    set_cnt_d   = '0;
                    mem_inval_d = mem_inval_i;
                    if (mem_inval_i) begin
                        // Memory side always names a single line
                        op_d    = cmo_pkg::CMO_INVAL_NLINE;
                        state_d = CHECK_NLINE;
                    end else if (req_i.op == cmo_pkg::CMO_FENCE) begin
                        wbuf_flush_all_o = rtab_empty_i;
                        if (!rtab_empty_i || !wbuf_empty_i) begin
                            state_d = FENCE_WAIT;
                        end
                    end else if (quiet) begin
                        state_d = inval_start;
                    end else begin
                        state_d = INVAL_WAIT;
                    end
                end
            end

            FENCE_WAIT: begin
                req_wait_o       = 1'b1;
                wbuf_flush_all_o = rtab_empty_i;
                if (wbuf_empty_i && rtab_empty_i) begin
                    state_d = IDLE;
                end
            end

            INVAL_WAIT: begin
                req_wait_o = 1'b1;
                if (quiet) begin
                    state_d = inval_start;
                end
            end

            CHECK_NLINE: begin
                // A refill may be writing the directory, so hold off
                if (!(mem_inval_q && dir_busy_i)) begin
                    dir_check_o = 1'b1;
                    state_d     = INVAL_SET;
                end
            end

            INVAL_SET: begin
                case (op_q)
                    cmo_pkg::CMO_INVAL_NLINE: begin
                        dir_inval_o     = |dir_check_hit_i;
                        dir_inval_way_o = dir_check_hit_i;
                        state_d         = IDLE;
                    end
                    cmo_pkg::CMO_INVAL_SET: begin
                        dir_inval_o     = 1'b1;
                        dir_inval_way_o = way_q;
                        state_d         = IDLE;
                    end
                    cmo_pkg::CMO_INVAL_ALL: begin
                        // Sweep one set per cycle
                        dir_inval_o     = 1'b1;
                        dir_inval_way_o = '1;
                        dir_inval_set_o = set_cnt_q;
                        set_cnt_d       = set_cnt_q + 1'b1;
                        if (set_cnt_q == cmo_pkg::cmo_set_t'(cmo_pkg::CMO_SETS - 1)) begin
                            state_d = IDLE;
                        end
                    end
                    default: begin
                        state_d = IDLE;
                    end
                endcase
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q        <= op_d;
        addr_q      <= addr_d;
        way_q       <= way_d;
        set_cnt_q   <= set_cnt_d;
        mem_inval_q <= mem_inval_d;
    end

endmodule

// File: hw/cache_dir.sv
// Tag and valid directory of the set-associative cache
// Refill, lookup, check and invalidate ports around one shared tag compare
module cache_dir (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Refill
    input  logic                  fill_valid_i,
    input  cmo_pkg::dir_fill_t    fill_i,
    output logic                  busy_o,

    // Lookup for observation
    input  logic                  lookup_valid_i,
    input  cmo_pkg::cmo_addr_t    lookup_addr_i,
    output cmo_pkg::cmo_way_vec_t lookup_hit_o,

    // Check from the handler
    input  logic                  check_i,
    input  cmo_pkg::cmo_set_t     check_set_i,
    input  cmo_pkg::cmo_tag_t     check_tag_i,
    output cmo_pkg::cmo_way_vec_t check_hit_way_o,

    // Invalidate
    input  logic                  inval_i,
    input  cmo_pkg::cmo_set_t     inval_set_i,
    input  cmo_pkg::cmo_way_vec_t inval_way_i
);

    logic [cmo_pkg::CMO_WAYS-1:0]  valid_q [cmo_pkg::CMO_SETS];
    cmo_pkg::cmo_tag_t             tag_q   [cmo_pkg::CMO_SETS][cmo_pkg::CMO_WAYS];

    cmo_pkg::cmo_set_t     cmp_set;
    cmo_pkg::cmo_tag_t     cmp_tag;
    cmo_pkg::cmo_way_vec_t cmp_hit;
    cmo_pkg::cmo_way_vec_t lookup_hit_q;
    cmo_pkg::cmo_way_vec_t check_hit_q;

    assign busy_o = fill_valid_i;

    // Check wins the comparator over lookup
    assign cmp_set = check_i ? check_set_i : cmo_pkg::cmo_addr_set(lookup_addr_i);
    assign cmp_tag = check_i ? check_tag_i : cmo_pkg::cmo_addr_tag(lookup_addr_i);

    always_comb begin
        for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
            cmp_hit[w] = valid_q[cmp_set][w] && (tag_q[cmp_set][w] == cmp_tag);
        end
    end

    assign lookup_hit_o    = lookup_hit_q;
    assign check_hit_way_o = check_hit_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_hit_q <= '0;
            check_hit_q  <= '0;
        end else begin
            if (check_i) begin
                check_hit_q <= cmp_hit;
            end else if (lookup_valid_i) begin
                lookup_hit_q <= cmp_hit;
            end
        end
    end

    // Valid bits; a fill lands after the invalidation so it survives a clash
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < cmo_pkg::CMO_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            if (inval_i) begin
                valid_q[inval_set_i] <= valid_q[inval_set_i] & ~inval_way_i;
            end
            if (fill_valid_i) begin
                for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
                    if (fill_i.way[w]) begin
                        valid_q[fill_i.set][w] <= 1'b1;
                    end
                end
            end
        end
    end

    // Tag array
    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
                if (fill_i.way[w]) begin
                    tag_q[fill_i.set][w] <= fill_i.tag;
                end
            end
        end
    end

endmodule

// File: hw/wbuf.sv
// Coalescing write buffer with flush-all and a valid/ready memory write port
module wbuf #(
    parameter int DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                wr_valid_i,
    input  cmo_pkg::wbuf_wr_t   wr_i,
    output logic                wr_ready_o,

    input  logic                flush_all_i,
    output logic                empty_o,

    output logic                mem_valid_o,
    output cmo_pkg::wbuf_wr_t   mem_wr_o,
    input  logic                mem_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cmo_pkg::wbuf_wr_t mem_q [DEPTH];

    logic [PTR_W-1:0] head_q, tail_q, last_ptr;
    logic [CNT_W-1:0] count_q;
    logic             full, hold_q;
    logic             push, pop, merge;

    assign full       = (count_q == CNT_W'(DEPTH));
    assign empty_o    = (count_q == '0);
    assign wr_ready_o = !full;
    assign last_ptr   = (tail_q == '0) ? PTR_W'(DEPTH - 1) : tail_q - 1'b1;

    // Head goes out once something newer sits behind it, or on flush/full
    assign mem_valid_o = !empty_o && (flush_all_i || full || count_q > 1 || hold_q);
    assign mem_wr_o    = mem_q[head_q];

    // No merging into an entry that is already on the memory port
    assign merge = !empty_o && (mem_q[last_ptr].addr == wr_i.addr)
                   && !(count_q == 1 && mem_valid_o);
    assign push  = wr_valid_i && wr_ready_o && !merge;
    assign pop   = mem_valid_o && mem_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            hold_q  <= 1'b0;
        end else begin
            if (push) begin
                tail_q <= (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
            // Keep offering a stalled head
            hold_q  <= mem_valid_o && !mem_ready_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[tail_q] <= wr_i;
        end else if (wr_valid_i && wr_ready_o && merge) begin
            mem_q[last_ptr].data <= wr_i.data;
        end
    end

endmodule

// File: hw/cmo_top.sv
// Cache-management subsystem top: handler, tag directory and write buffer
module cmo_top #(
    parameter int WBUF_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Management requests
    input  logic                  req_valid_i,
    input  cmo_pkg::cmo_req_t     req_i,
    input  logic                  mem_inval_i,
    output logic                  req_ready_o,
    output logic                  req_wait_o,

    // Quiet levels from the rest of the cache
    input  logic                  mshr_empty_i,
    input  logic                  rtab_empty_i,
    input  logic                  ctrl_empty_i,

    // Directory refill and lookup
    input  logic                  fill_valid_i,
    input  cmo_pkg::dir_fill_t    fill_i,
    input  logic                  lookup_valid_i,
    input  cmo_pkg::cmo_addr_t    lookup_addr_i,
    output cmo_pkg::cmo_way_vec_t lookup_hit_o,

    // Core writes and memory side
    input  logic                  wr_valid_i,
    input  cmo_pkg::wbuf_wr_t     wr_i,
    output logic                  wr_ready_o,
    output logic                  mem_valid_o,
    output cmo_pkg::wbuf_wr_t     mem_wr_o,
    input  logic                  mem_ready_i
);

    logic                  wbuf_empty, wbuf_flush_all;
    logic                  dir_check, dir_inval, dir_busy;
    cmo_pkg::cmo_set_t     dir_check_set, dir_inval_set;
    cmo_pkg::cmo_tag_t     dir_check_tag;
    cmo_pkg::cmo_way_vec_t dir_check_hit, dir_inval_way;

    cmo_handler u_handler (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .mem_inval_i     (mem_inval_i),
        .req_ready_o     (req_ready_o),
        .req_wait_o      (req_wait_o),
        .wbuf_empty_i    (wbuf_empty),
        .mshr_empty_i    (mshr_empty_i),
        .rtab_empty_i    (rtab_empty_i),
        .ctrl_empty_i    (ctrl_empty_i),
        .wbuf_flush_all_o(wbuf_flush_all),
        .dir_check_o     (dir_check),
        .dir_check_set_o (dir_check_set),
        .dir_check_tag_o (dir_check_tag),
        .dir_check_hit_i (dir_check_hit),
        .dir_inval_o     (dir_inval),
        .dir_inval_set_o (dir_inval_set),
        .dir_inval_way_o (dir_inval_way),
        .dir_busy_i      (dir_busy)
    );

    cache_dir u_dir (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .fill_valid_i   (fill_valid_i),
        .fill_i         (fill_i),
        .busy_o         (dir_busy),
        .lookup_valid_i (lookup_valid_i),
        .lookup_addr_i  (lookup_addr_i),
        .lookup_hit_o   (lookup_hit_o),
        .check_i        (dir_check),
        .check_set_i    (dir_check_set),
        .check_tag_i    (dir_check_tag),
        .check_hit_way_o(dir_check_hit),
        .inval_i        (dir_inval),
        .inval_set_i    (dir_inval_set),
        .inval_way_i    (dir_inval_way)
    );

    wbuf #(
        .DEPTH(WBUF_DEPTH)
    ) u_wbuf (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_valid_i (wr_valid_i),
        .wr_i       (wr_i),
        .wr_ready_o (wr_ready_o),
        .flush_all_i(wbuf_flush_all),
        .empty_o    (wbuf_empty),
        .mem_valid_o(mem_valid_o),
        .mem_wr_o   (mem_wr_o),
        .mem_ready_i(mem_ready_i)
    );

endmodule

// File: bench/cmo_properties.sv
// Concurrent assertions on the CMO handler request, directory and flush outputs
module cmo_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic req_valid_i,
    input logic req_ready_o,
    input logic dir_check_o,
    input logic dir_inval_o,
    input logic wbuf_flush_all_o,
    input logic rtab_empty_i
);

    // Requests only while the port is open
    valid_needs_ready: assert property (
        @(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> req_ready_o
    ) else $error("request valid while the handler was not ready");

    check_inval_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !(dir_check_o && dir_inval_o)
    ) else $error("directory check and invalidate in the same cycle");

    // Drain only once the replay table is quiet
    flush_needs_rtab: assert property (
        @(posedge clk_i) disable iff (!rst_ni) wbuf_flush_all_o |-> rtab_empty_i
    ) else $error("write buffer flush while the replay table was busy");

endmodule

// File: bench/cmo_checker.sv
// Watches lookup results and memory writes of the DUT, counts mismatches
module cmo_checker (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  exp_valid_i,
    input cmo_pkg::cmo_way_vec_t exp_hit_i,
    input cmo_pkg::cmo_way_vec_t lookup_hit_i,
    input logic                  mem_valid_i,
    input logic                  mem_ready_i,
    input cmo_pkg::wbuf_wr_t     mem_wr_i
);

    string              test_name = "none";
    int                 errors = 0;
    cmo_pkg::wbuf_wr_t  mem_exp [$];
    cmo_pkg::wbuf_wr_t  exp_wr;

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic expect_mem(input cmo_pkg::wbuf_wr_t wr);
        mem_exp.push_back(wr);
    endtask

    function automatic int pending();
        return mem_exp.size();
    endfunction

    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (exp_valid_i && (lookup_hit_i !== exp_hit_i)) begin
                $display("FAILED %s lookup hit expected %b actual %b",
                         test_name, exp_hit_i, lookup_hit_i);
                errors++;
            end
            // Memory writes come out in buffer order
            if (mem_valid_i && mem_ready_i) begin
                if (mem_exp.size() == 0) begin
                    $display("Unexpected memory write in %s to address %h",
                             test_name, mem_wr_i.addr);
                    errors++;
                end else begin
                    exp_wr = mem_exp.pop_front();
                    if (mem_wr_i !== exp_wr) begin
                        $display("FAILED %s memory write expected %h actual %h",
                                 test_name, exp_wr, mem_wr_i);
                        errors++;
                    end
                end
            end
        end
    end

endmodule

// File: bench/tb_cmo.sv
// Testbench for the cache-management subsystem
// Table of operations applied in a loop against a reference valid map
module tb_cmo;

    localparam int TIMEOUT = 300;

    typedef struct {
        string                 name;
        cmo_pkg::cmo_op_e      op;
        cmo_pkg::cmo_set_t     set;
        int                    tgt_way;
        bit                    absent;
        cmo_pkg::cmo_way_vec_t mask;
        bit                    mshr_low;
        bit                    mem_inval;
        bit                    refill;
        bit                    do_fill;
        cmo_pkg::cmo_way_vec_t exp_valid;
        int                    exp_busy;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic req_valid, mem_inval, req_ready, req_wait;
    logic mshr_empty, rtab_empty, ctrl_empty;
    logic fill_valid, lookup_valid, wr_valid, wr_ready, mem_valid, mem_ready;
    logic exp_valid, stall_en, mem_block;
    cmo_pkg::cmo_req_t     req;
    cmo_pkg::dir_fill_t    fill;
    cmo_pkg::cmo_addr_t    lookup_addr;
    cmo_pkg::cmo_way_vec_t lookup_hit, exp_hit;
    cmo_pkg::wbuf_wr_t     wr, mem_wr;

    // Reference directory contents
    cmo_pkg::cmo_way_vec_t ref_valid  [cmo_pkg::CMO_SETS];
    cmo_pkg::cmo_tag_t     ref_tag    [cmo_pkg::CMO_SETS][cmo_pkg::CMO_WAYS];
    bit                    ref_filled [cmo_pkg::CMO_SETS][cmo_pkg::CMO_WAYS];

    row_t rows [7];
    int   seq_errors = 0;
    int   timeouts = 0;

    always #4 clk_i = ~clk_i;

    always @(negedge clk_i) begin
        mem_ready <= mem_block ? 1'b0 : (stall_en ? (($urandom % 3) != 0) : 1'b1);
    end

    cmo_top #(.WBUF_DEPTH(4)) DUT (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .req_valid_i(req_valid), .req_i(req), .mem_inval_i(mem_inval),
        .req_ready_o(req_ready), .req_wait_o(req_wait),
        .mshr_empty_i(mshr_empty), .rtab_empty_i(rtab_empty), .ctrl_empty_i(ctrl_empty),
        .fill_valid_i(fill_valid), .fill_i(fill),
        .lookup_valid_i(lookup_valid), .lookup_addr_i(lookup_addr), .lookup_hit_o(lookup_hit),
        .wr_valid_i(wr_valid), .wr_i(wr), .wr_ready_o(wr_ready),
        .mem_valid_o(mem_valid), .mem_wr_o(mem_wr), .mem_ready_i(mem_ready)
    );

    cmo_checker u_checker (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .exp_valid_i(exp_valid), .exp_hit_i(exp_hit), .lookup_hit_i(lookup_hit),
        .mem_valid_i(mem_valid), .mem_ready_i(mem_ready), .mem_wr_i(mem_wr)
    );

    bind cmo_handler cmo_properties u_props (.*);

    function automatic cmo_pkg::cmo_way_vec_t ref_hit(cmo_pkg::cmo_set_t s, cmo_pkg::cmo_tag_t t);
        cmo_pkg::cmo_way_vec_t hit;
        for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
            hit[w] = ref_valid[s][w] && ref_filled[s][w] && (ref_tag[s][w] == t);
        end
        return hit;
    endfunction

    // All four ways of a set with distinct tags
    task automatic fill_set(input cmo_pkg::cmo_set_t s);
        cmo_pkg::cmo_tag_t base;
        base = 8'($urandom);
        for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
            @(negedge clk_i);
            fill_valid = 1'b1;
            fill = '{set: s, way: 4'(1 << w), tag: 8'(base + w)};
            ref_valid[s][w] = 1'b1;
            ref_tag[s][w] = 8'(base + w);
            ref_filled[s][w] = 1'b1;
        end
        @(negedge clk_i);
        fill_valid = 1'b0;
    endtask

    task automatic lookup_expect(input cmo_pkg::cmo_set_t s, input cmo_pkg::cmo_tag_t t);
        @(negedge clk_i);
        lookup_valid = 1'b1;
        lookup_addr = {t, s, 4'h0};
        @(negedge clk_i);
        lookup_valid = 1'b0;
        exp_valid = 1'b1;
        exp_hit = ref_hit(s, t);
        @(negedge clk_i);
        exp_valid = 1'b0;
    endtask

    task automatic sweep();
        for (int s = 0; s < cmo_pkg::CMO_SETS; s++) begin
            for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
                if (ref_filled[s][w]) begin
                    lookup_expect(4'(s), ref_tag[s][w]);
                end
            end
        end
    endtask

    task automatic issue(input cmo_pkg::cmo_op_e op, input cmo_pkg::cmo_addr_t addr,
                         input cmo_pkg::cmo_way_vec_t mask, input logic mi);
        @(negedge clk_i);
        req_valid = 1'b1;
        req = '{op: op, addr: addr, wdata: 32'(mask)};
        mem_inval = mi;
        @(negedge clk_i);
        req_valid = 1'b0;
        mem_inval = 1'b0;
    endtask

    task automatic wait_ready(output int busy);
        busy = 0;
        while (!req_ready && busy < TIMEOUT) begin
            @(negedge clk_i);
            busy++;
        end
        if (!req_ready) begin
            $display("Timeout: the request port never became ready again");
            timeouts++;
        end
    endtask

    task automatic write_word(input cmo_pkg::cmo_addr_t addr, input cmo_pkg::cmo_data_t data);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!wr_ready && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
        end
        if (!wr_ready) begin
            $display("Timeout: the write buffer never accepted a write");
            timeouts++;
        end
        wr_valid = 1'b1;
        wr = '{addr: addr, data: data};
        @(negedge clk_i);
        wr_valid = 1'b0;
    endtask

    // Second writes to A and B merge, the last A opens a new entry
    // Memory held off during the writes, so the four entries fill the buffer
    task automatic run_fence();
        int busy;
        mem_block = 1'b1;
        u_checker.expect_mem('{addr: 16'h1230, data: 32'h0000_0002});
        u_checker.expect_mem('{addr: 16'h4560, data: 32'h0000_0004});
        u_checker.expect_mem('{addr: 16'h7890, data: 32'h0000_0005});
        u_checker.expect_mem('{addr: 16'h1230, data: 32'h0000_0006});
        write_word(16'h1230, 32'h1);
        write_word(16'h1230, 32'h2);
        write_word(16'h4560, 32'h3);
        write_word(16'h4560, 32'h4);
        write_word(16'h7890, 32'h5);
        write_word(16'h1230, 32'h6);
        if (wr_ready !== 1'b0) begin
            $display("FAILED %s write ready when full expected 0 actual %b",
                     u_checker.test_name, wr_ready);
            seq_errors++;
        end
        mem_block = 1'b0;
        stall_en = 1'b1;
        issue(cmo_pkg::CMO_FENCE, '0, '0, 1'b0);
        wait_ready(busy);
        if (u_checker.pending() != 0 || mem_valid) begin
            $display("Fence finished while buffered writes were still pending");
            seq_errors++;
        end
        stall_en = 1'b0;
    endtask

    initial begin
        row_t              r;
        cmo_pkg::cmo_tag_t t;
        int                busy;

        void'($urandom(32'hea6db9a5));
        rst_ni = 1'b0;
        req_valid = 1'b0;
        req = '0;
        mem_inval = 1'b0;
        mshr_empty = 1'b1;
        rtab_empty = 1'b1;
        ctrl_empty = 1'b1;
        fill_valid = 1'b0;
        fill = '0;
        lookup_valid = 1'b0;
        lookup_addr = '0;
        wr_valid = 1'b0;
        wr = '0;
        mem_ready = 1'b1;
        exp_valid = 1'b0;
        exp_hit = '0;
        stall_en = 1'b0;
        mem_block = 1'b0;
        for (int s = 0; s < cmo_pkg::CMO_SETS; s++) begin
            ref_valid[s] = '0;
            for (int w = 0; w < cmo_pkg::CMO_WAYS; w++) begin
                ref_tag[s][w] = '0;
                ref_filled[s][w] = 1'b0;
            end
        end

        // name, op, set, way, absent, mask, mshr low, mem inval, refill, fill, valid, busy
        rows[0] = '{"inval_line_hit", cmo_pkg::CMO_INVAL_NLINE, 4'd3, 2, 0, 4'b0000,
                    0, 0, 0, 1, 4'b1011, 2};
        rows[1] = '{"inval_line_absent", cmo_pkg::CMO_INVAL_NLINE, 4'd5, 0, 1, 4'b0000,
                    0, 0, 0, 1, 4'b1111, 2};
        rows[2] = '{"inval_set_mask", cmo_pkg::CMO_INVAL_SET, 4'd7, 0, 0, 4'b0101,
                    0, 0, 0, 1, 4'b1010, 1};
        rows[3] = '{"inval_wait_mshr", cmo_pkg::CMO_INVAL_SET, 4'd9, 0, 0, 4'b1111,
                    1, 0, 0, 1, 4'b0000, -1};
        rows[4] = '{"mem_inval_refill", cmo_pkg::CMO_INVAL_NLINE, 4'd11, 1, 0, 4'b0000,
                    1, 1, 1, 1, 4'b1101, -1};
        rows[5] = '{"fence_drain", cmo_pkg::CMO_FENCE, 4'd0, 0, 0, 4'b0000,
                    0, 0, 0, 0, 4'b0000, -1};
        rows[6] = '{"inval_all", cmo_pkg::CMO_INVAL_ALL, 4'd0, 0, 0, 4'b0000,
                    0, 0, 0, 1, 4'b0000, 16};

        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        foreach (rows[i]) begin
            r = rows[i];
            u_checker.set_test(r.name);
            if (r.do_fill) begin
                fill_set(r.set);
            end
            t = r.absent ? 8'(ref_tag[r.set][0] + 7) : ref_tag[r.set][r.tgt_way];
            if (r.op == cmo_pkg::CMO_FENCE) begin
                run_fence();
                continue;
            end
            mshr_empty = !r.mshr_low;
            if (r.refill) begin
                // Long refill into another set keeps the directory busy
                fill_valid = 1'b1;
                fill = '{set: 4'd12, way: 4'b0001, tag: 8'($urandom)};
                ref_valid[12][0] = 1'b1;
                ref_tag[12][0] = fill.tag;
                ref_filled[12][0] = 1'b1;
            end
            issue(r.op, {t, r.set, 4'h0}, r.mask, r.mem_inval);
            if (r.refill) begin
                repeat (5) begin
                    @(negedge clk_i);
                    if (req_ready) begin
                        $display("Memory invalidation completed during a refill");
                        seq_errors++;
                    end
                end
                fill_valid = 1'b0;
            end else if (r.mshr_low) begin
                repeat (4) begin
                    lookup_expect(r.set, ref_tag[r.set][0]);
                    if (!req_wait || req_ready) begin
                        $display("Invalidation went ahead while the MSHRs were busy");
                        seq_errors++;
                    end
                end
                mshr_empty = 1'b1;
            end
            wait_ready(busy);
            mshr_empty = 1'b1;
            if (r.exp_busy >= 0 && busy != r.exp_busy) begin
                $display("FAILED %s busy cycles expected %0d actual %0d",
                         r.name, r.exp_busy, busy);
                seq_errors++;
            end
            if (r.op == cmo_pkg::CMO_INVAL_ALL) begin
                for (int s = 0; s < cmo_pkg::CMO_SETS; s++) begin
                    ref_valid[s] = '0;
                end
            end else begin
                ref_valid[r.set] = r.exp_valid;
            end
            sweep();
        end

        repeat (4) @(negedge clk_i);
        $display("Errors: %0d compare, %0d sequence, %0d timeout",
                 u_checker.errors, seq_errors, timeouts);
        if (u_checker.errors == 0 && seq_errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
hw/cmo_pkg.sv
hw/cmo_handler.sv
hw/cache_dir.sv
hw/wbuf.sv
hw/cmo_top.sv
bench/cmo_properties.sv
bench/cmo_checker.sv
bench/tb_cmo.sv
